// File: Bender.yml
package:
  name: operand_dispatch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/od_pkg.sv
      - hdl/phys_regfile.sv
      - hdl/dispatch_buffer.sv
      - hdl/operand_issue.sv
      - hdl/operand_dispatch.sv
      - target: simulation
        files:
          - testbench/tb_operand_dispatch.sv

// File: hdl/dispatch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "od_cfg.svh"

module dispatch_buffer
(
  input  wire                                          clock,
  input  wire                                          rst,
  input  wire                                          flush,     // Mispredict recovery
  input  wire od_pkg::room_t                           room,      // Free slots downstream
  input  wire od_pkg::slot_mask_t                      in_valid,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   in_pdest,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   in_srca,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   in_srcb,
  input  wire od_pkg::alu_func_t     [`OD_SLOTS-1:0]   in_func,
  output logic                                         in_ready,
  output od_pkg::slot_mask_t                           dsp_valid,
  output od_pkg::preg_t              [`OD_SLOTS-1:0]   dsp_pdest,
  output od_pkg::preg_t              [`OD_SLOTS-1:0]   dsp_srca,
  output od_pkg::preg_t              [`OD_SLOTS-1:0]   dsp_srcb,
  output od_pkg::alu_func_t          [`OD_SLOTS-1:0]   dsp_func
);

  // ID/DP pair
  od_pkg::slot_mask_t                   buf_valid;
  od_pkg::preg_t        [`OD_SLOTS-1:0] buf_pdest;
  od_pkg::preg_t        [`OD_SLOTS-1:0] buf_srca;
  od_pkg::preg_t        [`OD_SLOTS-1:0] buf_srcb;
  od_pkg::alu_func_t    [`OD_SLOTS-1:0] buf_func;

  od_pkg::room_t occupancy;
  logic          compact;

  ////////////////////////////////////////////////////////////
  // Dispatch decision
  ////////////////////////////////////////////////////////////

  assign occupancy = od_pkg::room_t'(buf_valid[0]) + od_pkg::room_t'(buf_valid[1]);

  // Free for a new pair once every occupant leaves
  assign in_ready = (occupancy <= room);

  // Two held, one slot free downstream
  assign compact = (occupancy == 2'd2) && (room == 2'd1);

  // Leave in slot order, at most room of them
  assign dsp_valid[0] = buf_valid[0] && (room != 2'd0);
  assign dsp_valid[1] = buf_valid[1] && (room >= 2'd2);

  assign dsp_pdest = buf_pdest;
  assign dsp_srca  = buf_srca;
  assign dsp_srcb  = buf_srcb;
  assign dsp_func  = buf_func;

  ////////////////////////////////////////////////////////////
  // Buffer update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst || flush)
    begin
      buf_valid <= '0; // Flush drops a pair taken on the same edge
    end
    else if (in_ready)
    begin
      buf_valid <= in_valid;
    end
    else if (compact)
    begin
      buf_valid <= od_pkg::slot_mask_t'(1); // Younger now sits in slot 0
    end
  end

  always_ff @(posedge clock)
  begin
    if (in_ready)
    begin
      buf_pdest <= in_pdest;
      buf_srca  <= in_srca;
      buf_srcb  <= in_srcb;
      buf_func  <= in_func;
    end
    else if (compact)
    begin
      // Move slot 1 down into slot 0
      buf_pdest[0] <= buf_pdest[1];
      buf_srca[0]  <= buf_srca[1];
      buf_srcb[0]  <= buf_srcb[1];
      buf_func[0]  <= buf_func[1];
    end
  end

  // Slot 1 never holds an instruction without an older one in slot 0
  a_slot_order: assert property (@(posedge clock) disable iff (rst)
    !(buf_valid[1] && !buf_valid[0]));

endmodule

`default_nettype wire

// File: hdl/od_cfg.svh
`ifndef OD_CFG_SVH
`define OD_CFG_SVH

// Instructions per dispatch pair
`define OD_SLOTS        2

// Physical register file
`define OD_PRF_ENTRIES  64
`define OD_PREG_BITS    6

// Datapath widths
`define OD_WORD_BITS    64
`define OD_ALU_BITS     5

// Hardwired zero register
`define OD_ZERO_PREG    0

`endif

// File: hdl/od_pkg.sv
`default_nettype none

`include "od_cfg.svh"

package od_pkg;

  // Physical register tag
  typedef logic [`OD_PREG_BITS-1:0] preg_t;

  typedef logic [`OD_WORD_BITS-1:0] word_t;     // Operand or result word
  typedef logic [`OD_ALU_BITS-1:0]  alu_func_t; // ALU function code

  // One bit per slot, bit 0 the older instruction
  typedef logic [`OD_SLOTS-1:0] slot_mask_t;

  // Free issue slots downstream, 0 to OD_SLOTS
  typedef logic [$clog2(`OD_SLOTS+1)-1:0] room_t;

endpackage

`default_nettype wire

// File: hdl/operand_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "od_cfg.svh"

module operand_dispatch
(
  input  wire                                          clock,
  input  wire                                          rst,
  input  wire                                          flush,
  input  wire od_pkg::room_t                           room,
  input  wire od_pkg::slot_mask_t                      in_valid,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   in_pdest,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   in_srca,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   in_srcb,
  input  wire od_pkg::alu_func_t     [`OD_SLOTS-1:0]   in_func,
  input  wire od_pkg::slot_mask_t                      cdb_valid,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   cdb_tag,
  input  wire od_pkg::word_t         [`OD_SLOTS-1:0]   cdb_value,
  output logic                                         in_ready,
  output od_pkg::slot_mask_t                           iss_valid,
  output od_pkg::preg_t              [`OD_SLOTS-1:0]   iss_pdest,
  output od_pkg::alu_func_t          [`OD_SLOTS-1:0]   iss_func,
  output od_pkg::word_t              [`OD_SLOTS-1:0]   iss_opa,
  output od_pkg::word_t              [`OD_SLOTS-1:0]   iss_opb
);

  // Buffer to issue stage
  od_pkg::slot_mask_t                    dsp_valid;
  od_pkg::preg_t      [`OD_SLOTS-1:0]    dsp_pdest;
  od_pkg::preg_t      [`OD_SLOTS-1:0]    dsp_srca;
  od_pkg::preg_t      [`OD_SLOTS-1:0]    dsp_srcb;
  od_pkg::alu_func_t  [`OD_SLOTS-1:0]    dsp_func;

  // Register file read ports
  od_pkg::preg_t      [2*`OD_SLOTS-1:0]  rd_tag;
  od_pkg::word_t      [2*`OD_SLOTS-1:0]  rd_data;

  for (genvar s = 0; s < `OD_SLOTS; s++)
  begin : g_rd_tag
    assign rd_tag[2*s]   = dsp_srca[s];
    assign rd_tag[2*s+1] = dsp_srcb[s];
  end

  ////////////////////////////////////////////////////////////
  // ID/DP, register file, IS/EX
  ////////////////////////////////////////////////////////////

  dispatch_buffer dispatch_buffer_inst
  (
    .clock     (clock),
    .rst       (rst),
    .flush     (flush),
    .room      (room),
    .in_valid  (in_valid),
    .in_pdest  (in_pdest),
    .in_srca   (in_srca),
    .in_srcb   (in_srcb),
    .in_func   (in_func),
    .in_ready  (in_ready),
    .dsp_valid (dsp_valid),
    .dsp_pdest (dsp_pdest),
    .dsp_srca  (dsp_srca),
    .dsp_srcb  (dsp_srcb),
    .dsp_func  (dsp_func)
  );

  phys_regfile phys_regfile_inst
  (
    .clock     (clock),
    .rst       (rst),
    .rd_tag    (rd_tag),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .rd_data   (rd_data)
  );

  operand_issue operand_issue_inst
  (
    .clock     (clock),
    .rst       (rst),
    .flush     (flush),
    .dsp_valid (dsp_valid),
    .dsp_pdest (dsp_pdest),
    .dsp_func  (dsp_func),
    .dsp_srca  (dsp_srca),
    .dsp_srcb  (dsp_srcb),
    .rd_data   (rd_data),   // Bypassed against the same CDB
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .iss_valid (iss_valid),
    .iss_pdest (iss_pdest),
    .iss_func  (iss_func),
    .iss_opa   (iss_opa),
    .iss_opb   (iss_opb)
  );

endmodule

`default_nettype wire

// File: hdl/operand_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "od_cfg.svh"

module operand_issue
(
  input  wire                                          clock,
  input  wire                                          rst,
  input  wire                                          flush,
  input  wire od_pkg::slot_mask_t                      dsp_valid,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   dsp_pdest,
  input  wire od_pkg::alu_func_t     [`OD_SLOTS-1:0]   dsp_func,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   dsp_srca,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   dsp_srcb,
  input  wire od_pkg::word_t         [2*`OD_SLOTS-1:0] rd_data,
  input  wire od_pkg::slot_mask_t                      cdb_valid,
  input  wire od_pkg::preg_t         [`OD_SLOTS-1:0]   cdb_tag,
  input  wire od_pkg::word_t         [`OD_SLOTS-1:0]   cdb_value,
  output od_pkg::slot_mask_t                           iss_valid,
  output od_pkg::preg_t              [`OD_SLOTS-1:0]   iss_pdest,
  output od_pkg::alu_func_t          [`OD_SLOTS-1:0]   iss_func,
  output od_pkg::word_t              [`OD_SLOTS-1:0]   iss_opa,
  output od_pkg::word_t              [`OD_SLOTS-1:0]   iss_opb
);

  od_pkg::preg_t [2*`OD_SLOTS-1:0] op_tag;
  od_pkg::word_t [2*`OD_SLOTS-1:0] op_value;

  // Pick the CDB value over the register file on a tag match
  function automatic od_pkg::word_t bypass
  (
    input od_pkg::preg_t                  tag,
    input od_pkg::word_t                  rf_value,
    input od_pkg::slot_mask_t             bus_valid,
    input od_pkg::preg_t [`OD_SLOTS-1:0]  bus_tag,
    input od_pkg::word_t [`OD_SLOTS-1:0]  bus_value
  );
    od_pkg::word_t result;
    result = rf_value;
    // Highest port first so CDB slot 0 wins
    for (int p = `OD_SLOTS-1; p >= 0; p--)
    begin
      if (bus_valid[p] && (bus_tag[p] == tag))
      begin
        result = bus_value[p];
      end
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // Operand bypass
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < `OD_SLOTS; s++)
  begin : g_tag
    assign op_tag[2*s]   = dsp_srca[s]; // Same order as register file reads
    assign op_tag[2*s+1] = dsp_srcb[s];
  end

  for (genvar r = 0; r < 2*`OD_SLOTS; r++)
  begin : g_bypass
    assign op_value[r] = bypass(op_tag[r], rd_data[r], cdb_valid, cdb_tag, cdb_value);
  end

  ////////////////////////////////////////////////////////////
  // IS/EX register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst || flush)
    begin
      iss_valid <= '0;
    end
    else
    begin
      iss_valid <= dsp_valid; // Loads every cycle, no stall
    end
  end

  always_ff @(posedge clock)
  begin
    iss_pdest <= dsp_pdest;
    iss_func  <= dsp_func;
    for (int s = 0; s < `OD_SLOTS; s++)
    begin
      iss_opa[s] <= op_value[2*s];
      iss_opb[s] <= op_value[2*s+1];
    end
  end

endmodule

`default_nettype wire

// File: hdl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "od_cfg.svh"

module phys_regfile
(
  input  wire                                        clock,
  input  wire                                        rst,
  // Slot 0 a, slot 0 b, slot 1 a, slot 1 b
  input  wire od_pkg::preg_t     [2*`OD_SLOTS-1:0]   rd_tag,
  input  wire od_pkg::slot_mask_t                    cdb_valid,
  input  wire od_pkg::preg_t     [`OD_SLOTS-1:0]     cdb_tag,
  input  wire od_pkg::word_t     [`OD_SLOTS-1:0]     cdb_value,
  output od_pkg::word_t          [2*`OD_SLOTS-1:0]   rd_data
);

  localparam od_pkg::preg_t zero_tag = od_pkg::preg_t'(`OD_ZERO_PREG);

  od_pkg::word_t regs [`OD_PRF_ENTRIES];

  ////////////////////////////////////////////////////////////
  // CDB write ports
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      for (int i = 0; i < `OD_PRF_ENTRIES; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < `OD_SLOTS; p++)
      begin
        if (cdb_valid[p])
        begin
          regs[cdb_tag[p]] <= cdb_value[p]; // Tags never collide
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand read ports
  ////////////////////////////////////////////////////////////

  // Combinational, new writes show up next cycle
  for (genvar r = 0; r < 2*`OD_SLOTS; r++)
  begin : g_read
    assign rd_data[r] = (rd_tag[r] == zero_tag) ? '0 : regs[rd_tag[r]];
  end

  // Zero register is never a CDB destination
  for (genvar p = 0; p < `OD_SLOTS; p++)
  begin : g_cdb_check
    a_cdb_not_zero: assert property (@(posedge clock) disable iff (rst)
      cdb_valid[p] |-> (cdb_tag[p] != zero_tag));
  end

  // Both CDB ports never target one register in the same cycle
  a_cdb_distinct: assert property (@(posedge clock) disable iff (rst)
    (&cdb_valid) |-> (cdb_tag[0] != cdb_tag[1]));

endmodule

`default_nettype wire

// File: testbench/tb_operand_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "od_cfg.svh"

module tb_operand_dispatch;

  typedef struct packed
  {
    od_pkg::preg_t     pdest;
    od_pkg::preg_t     srca;
    od_pkg::preg_t     srcb;
    od_pkg::alu_func_t func;
  } inst_t;

  typedef struct packed
  {
    logic              slot;  // Issue slot it must appear in
    od_pkg::preg_t     pdest;
    od_pkg::alu_func_t func;
    od_pkg::word_t     opa;
    od_pkg::word_t     opb;
  } issued_t;

  logic                                  clock;
  logic                                  rst;
  logic                                  flush;
  od_pkg::room_t                         room;
  od_pkg::slot_mask_t                    in_valid;
  od_pkg::preg_t     [`OD_SLOTS-1:0]     in_pdest;
  od_pkg::preg_t     [`OD_SLOTS-1:0]     in_srca;
  od_pkg::preg_t     [`OD_SLOTS-1:0]     in_srcb;
  od_pkg::alu_func_t [`OD_SLOTS-1:0]     in_func;
  od_pkg::slot_mask_t                    cdb_valid;
  od_pkg::preg_t     [`OD_SLOTS-1:0]     cdb_tag;
  od_pkg::word_t     [`OD_SLOTS-1:0]     cdb_value;
  logic                                  in_ready;
  od_pkg::slot_mask_t                    iss_valid;
  od_pkg::preg_t     [`OD_SLOTS-1:0]     iss_pdest;
  od_pkg::alu_func_t [`OD_SLOTS-1:0]     iss_func;
  od_pkg::word_t     [`OD_SLOTS-1:0]     iss_opa;
  od_pkg::word_t     [`OD_SLOTS-1:0]     iss_opb;

  // Reference model state
  od_pkg::word_t shadow [`OD_PRF_ENTRIES];
  inst_t         pending [$];   // Accepted, not yet dispatched
  issued_t       expected [$];  // Dispatched, waiting on the issue outputs
  od_pkg::preg_t written [$];
  inst_t         pair [`OD_SLOTS];

  integer seed = 32'h459d_c1cd;
  string  cur_test;
  int     test_errors;
  int     tests_passed;
  int     tests_failed;

  operand_dispatch operand_dispatch_inst
  (
    .clock     (clock),
    .rst       (rst),
    .flush     (flush),
    .room      (room),
    .in_valid  (in_valid),
    .in_pdest  (in_pdest),
    .in_srca   (in_srca),
    .in_srcb   (in_srcb),
    .in_func   (in_func),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .in_ready  (in_ready),
    .iss_valid (iss_valid),
    .iss_pdest (iss_pdest),
    .iss_func  (iss_func),
    .iss_opa   (iss_opa),
    .iss_opb   (iss_opb)
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Operand value seen in the dispatch cycle
  function automatic od_pkg::word_t predict_operand(input od_pkg::preg_t tag);
    od_pkg::word_t value;
    value = shadow[tag];
    if (cdb_valid[1] && (cdb_tag[1] == tag))
      value = cdb_value[1];
    if (cdb_valid[0] && (cdb_tag[0] == tag))
      value = cdb_value[0];   // CDB slot 0 has priority
    if (tag == `OD_ZERO_PREG)
      value = '0;
    return value;
  endfunction

  always @(posedge clock)
  begin : model_step
    int      leaving;
    logic    ready;
    inst_t   inst;
    issued_t item;
    if (rst)
    begin
      pending.delete();
      expected.delete();
      for (int i = 0; i < `OD_PRF_ENTRIES; i++)
        shadow[i] = '0;
    end
    else
    begin
      ready = (pending.size() <= room);
      check("in_ready", ready, in_ready);
      leaving = (pending.size() < room) ? pending.size() : room;
      for (int i = 0; i < leaving; i++)
      begin
        inst = pending.pop_front();
        item = '{i[0], inst.pdest, inst.func,
                 predict_operand(inst.srca), predict_operand(inst.srcb)};
        if (!flush)
          expected.push_back(item);  // Flush kills it in the issue register
      end
      if (flush)
        pending.delete();
      else if (ready)
      begin
        for (int s = 0; s < `OD_SLOTS; s++)
        begin
          if (in_valid[s])
          begin
            inst.pdest = in_pdest[s];
            inst.srca  = in_srca[s];
            inst.srcb  = in_srcb[s];
            inst.func  = in_func[s];
            pending.push_back(inst);
          end
        end
      end
      for (int p = 0; p < `OD_SLOTS; p++)
      begin
        if (cdb_valid[p])
          shadow[cdb_tag[p]] = cdb_value[p];
      end
    end
  end

  // Compare the issue outputs with the model, slot 0 first
  always @(posedge clock)
  begin : compare_issue
    issued_t item;
    if (!rst)
    begin
      for (int s = 0; s < `OD_SLOTS; s++)
      begin
        if (iss_valid[s] === 1'b1)
        begin
          if (expected.size() == 0)
          begin
            $display("%s: issue slot %0d valid with no instruction due", cur_test, s);
            test_errors++;
          end
          else
          begin
            item = expected.pop_front();
            check("issue slot", item.slot, s);
            check("pdest", item.pdest, iss_pdest[s]);
            check("func", item.func, iss_func[s]);
            check("opa", item.opa, iss_opa[s]);
            check("opb", item.opb, iss_opb[s]);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [63:0] exp_value,
                       input logic [63:0] act_value);
    if (exp_value !== act_value)
    begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp_value, act_value);
      test_errors++;
    end
  endtask

  task automatic finish_run();
    if (test_errors != 0)
      tests_failed++;   // Aborted test or late mismatches
    $display("Tests passed: %0d, tests failing: %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  endtask

  task automatic abort_run(input string reason);
    $display("%s: %s", cur_test, reason);
    test_errors++;
    finish_run();
  endtask

  task automatic start_test(input string name);
    cur_test = name;
  endtask

  // Prefer tags the CDB has written
  function automatic od_pkg::preg_t pick_tag();
    int unsigned r;
    r = $unsigned($random(seed));
    if (written.size() == 0)
      return od_pkg::preg_t'(r);
    return written[r % written.size()];
  endfunction

  task automatic randomize_pair();
    for (int s = 0; s < `OD_SLOTS; s++)
    begin
      pair[s].pdest = od_pkg::preg_t'($unsigned($random(seed)));
      pair[s].srca  = pick_tag();
      pair[s].srcb  = pick_tag();
      pair[s].func  = od_pkg::alu_func_t'($unsigned($random(seed)));
    end
  endtask

  // Called on a rising edge, returns on the edge that takes the pair
  task automatic offer_pair(input od_pkg::slot_mask_t mask, input od_pkg::room_t room_val);
    int cycles;
    in_valid <= mask;
    room     <= room_val;
    for (int s = 0; s < `OD_SLOTS; s++)
    begin
      in_pdest[s] <= pair[s].pdest;
      in_srca[s]  <= pair[s].srca;
      in_srcb[s]  <= pair[s].srcb;
      in_func[s]  <= pair[s].func;
    end
    cycles = 0;
    do
    begin
      @(posedge clock);
      cycles++;
      if (cycles > 20)
        abort_run("the pair was never accepted, in_ready stayed low");
    end
    while (!in_ready);
    in_valid <= '0;
  endtask

  task automatic drive_random_cdb();
    od_pkg::preg_t t0;
    od_pkg::preg_t t1;
    t0 = 1 + $unsigned($random(seed)) % 63;
    t1 = 1 + (t0 + $unsigned($random(seed)) % 62) % 63; // Distinct and nonzero
    cdb_valid    <= 2'b11;
    cdb_tag[0]   <= t0;
    cdb_tag[1]   <= t1;
    cdb_value[0] <= {$random(seed), $random(seed)};
    cdb_value[1] <= {$random(seed), $random(seed)};
    written.push_back(t0);
    written.push_back(t1);
    @(posedge clock);
  endtask

  // Sampled on the falling edge, where the model queues are settled
  task automatic wait_drain();
    int cycles;
    in_valid  <= '0;
    cdb_valid <= '0;
    cycles = 0;
    do
    begin
      @(negedge clock);
      cycles++;
      if (cycles > 40)
        abort_run("instructions were still waiting to issue after 40 cycles");
    end
    while ((pending.size() != 0) || (expected.size() != 0));
  endtask

  task automatic end_test();
    wait_drain();
    $display("%s finished with %0d mismatches", cur_test, test_errors);
    if (test_errors == 0)
      tests_passed++;
    else
      tests_failed++;
    test_errors = 0;
    @(posedge clock);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst          = 1'b1;
    flush        = 1'b0;
    room         = 2'd2;
    in_valid     = '0;
    in_pdest     = '0;
    in_srca      = '0;
    in_srcb      = '0;
    in_func      = '0;
    cdb_valid    = '0;
    cdb_tag      = '0;
    cdb_value    = '0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    start_test("reset");
    repeat (5) @(posedge clock);
    rst <= 1'b0;

    start_test("after_reset");
    @(posedge clock);
    check("iss_valid", '0, iss_valid);
    check("in_ready", 1'b1, in_ready);
    for (int k = 0; k < 3; k++)
    begin
      randomize_pair();   // Nothing written yet, all reads are zero
      offer_pair(2'b11, 2'd2);
    end
    end_test();

    start_test("regfile_read");
    repeat (16) drive_random_cdb();
    cdb_valid <= '0;
    for (int k = 0; k < 6; k++)
    begin
      randomize_pair();
      if (k == 0)
        pair[0].srca = `OD_ZERO_PREG;
      offer_pair((k == 5) ? 2'b01 : 2'b11, 2'd2);
    end
    end_test();

    start_test("cdb_bypass");
    randomize_pair();
    pair[0].srca = 6'd10;
    pair[1].srca = 6'd10;
    pair[0].srcb = 6'd21;
    pair[1].srcb = 6'd33;
    offer_pair(2'b11, 2'd2);
    cdb_valid    <= 2'b11;  // Same cycle the pair dispatches
    cdb_tag[0]   <= 6'd10;
    cdb_tag[1]   <= 6'd21;
    cdb_value[0] <= {$random(seed), $random(seed)};
    cdb_value[1] <= {$random(seed), $random(seed)};
    @(posedge clock);
    cdb_valid <= '0;
    end_test();

    start_test("partial_room");
    randomize_pair();
    offer_pair(2'b11, 2'd1);
    end_test();
    room <= 2'd2;

    start_test("zero_room");
    randomize_pair();
    offer_pair(2'b11, 2'd0);
    repeat (6) @(posedge clock);
    room <= 2'd2;
    end_test();

    start_test("flush");
    randomize_pair();
    offer_pair(2'b11, 2'd2);
    randomize_pair();
    offer_pair(2'b11, 2'd2);
    room  <= 2'd1;    // Second pair half dispatched while the first sits in IS/EX
    flush <= 1'b1;
    @(posedge clock);
    flush <= 1'b0;
    room  <= 2'd2;
    @(posedge clock);
    check("iss_valid after flush", '0, iss_valid);
    check("in_ready after flush", 1'b1, in_ready);
    randomize_pair();
    offer_pair(2'b11, 2'd2);
    end_test();

    @(negedge clock);
    finish_run();
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/od_pkg.sv
hdl/phys_regfile.sv
hdl/dispatch_buffer.sv
hdl/operand_issue.sv
hdl/operand_dispatch.sv
testbench/tb_operand_dispatch.sv
